// File: Makefile
# Verilator flow for the ROM download front end

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f gba_loader_top.f --top-module gba_loader_top

# Passes only when the pass message shows up in the simulation output
sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f gba_loader_top.f --top-module gba_loader_tb -o gba_loader_sim
	out="$$(./obj_dir/gba_loader_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: gba_loader_top.f
+incdir+logic
logic/gba_loader_pkg.sv
logic/download_bus_if.sv
logic/download_decoder.sv
logic/bios_word_packer.sv
logic/cheat_code_packer.sv
logic/cart_header_scan.sv
logic/gba_loader_top.sv
verif/gba_loader_tb.sv

// File: logic/bios_word_packer.sv
`timescale 1ns/100ps
/* Packs BIOS halfwords from the download bus into 32-bit words.
   One write pulse per word, none while the built-in boot code is selected */
`include "gba_loader_settings.svh"

module bios_word_packer import gba_loader_pkg::*; (
	input  logic            clk_sys,
	input  logic            reset,
	download_bus_if.sink    bus,
	input  logic            bios_lock,
	output bios_addr_t      bios_wraddr,
	output bios_word_t      bios_wrdata,
	output logic            bios_wr
);
	logic take;   // Write belongs to us
	logic high;   // Upper halfword of the word

	assign take = bus.bios_load & bus.wr & ~bios_lock;
	assign high = bus.addr[1];

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= take & high; // Word complete
	end

	// Data and address path
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (~high) begin
				bios_wrdata[`LOAD_DATA_W-1:0] <= bus.data;
			end else begin
				bios_wrdata[`BIOS_WORD_W-1:`LOAD_DATA_W] <= bus.data;
				bios_wraddr <= bus.addr[`BIOS_ADDR_W+1:2];
			end
		end
	end

endmodule

// File: logic/cart_header_scan.sv
`timescale 1ns/100ps
/* Scans the cartridge stream for the 1M flash save tag and looks up
   the header title in the quirk table. Cleared at each cartridge start */
`include "gba_loader_settings.svh"

module cart_header_scan import gba_loader_pkg::*; (
	input  logic            clk_sys,
	input  logic            reset,
	download_bus_if.sink    bus,
	input  logic            cart_start,
	output logic            flash_1m,
	output quirk_set_t      quirks
);
	// ==================================================
	// Quirk table
	// ==================================================
	function automatic quirk_set_t quirk_lookup(input header_id_t id);
		quirk_set_t q;
		q = '0;
		case (id)
			"ROCKY BOXING": begin
				q[`QUIRK_SRAM] = 1'b1;
			end
			{"BOMBER MAN", 16'h0000}: begin // NES classic, needs remap
				q[`QUIRK_SRAM]  = 1'b1;
				q[`QUIRK_REMAP] = 1'b1;
			end
			{"ZELDA 1", 40'h0000000000}: begin
				q[`QUIRK_SRAM]  = 1'b1;
				q[`QUIRK_REMAP] = 1'b1;
			end
			"POKEMON EMER": begin
				q[`QUIRK_GPIO] = 1'b1; // RTC on cart
			end
			{"BOKTAI", 48'h000000000000}: begin
				q[`QUIRK_GPIO]  = 1'b1;
				q[`QUIRK_SOLAR] = 1'b1; // Light sensor
			end
			"WARIOTWISTED": begin
				q[`QUIRK_GPIO] = 1'b1;
			end
			{"YOSHI TOPSY", 8'h00}: begin
				q[`QUIRK_TILT] = 1'b1;
			end
			"SENNENKAZOKU": begin
				q[`QUIRK_GPIO] = 1'b1;
			end
			default: ;
		endcase
		return q;
	endfunction

	logic                        cart_wr;
	logic                        title_line;  // Write falls in header line A
	logic [3:0]                  id_slot;
	logic [6:0]                  id_lsb;
	logic [`FLASH_TAG_W-9:0]     history;     // Last eight bytes, newest at the bottom
	logic [`FLASH_TAG_W-1:0]     tag_even;
	logic [`FLASH_TAG_W-1:0]     tag_odd;
	header_id_t                  cart_id;

	assign cart_wr    = bus.cart_load & bus.wr;
	assign title_line = (bus.addr[`LOAD_ADDR_W-1:4] == `HEADER_ID_LINE);

	// Offset 0 lands in the top halfword of the title
	assign id_slot = 4'(`HEADER_ID_CHECK - 2) - bus.addr[3:0];
	assign id_lsb  = {id_slot, 3'b000};

	// Tag may end on the low or on the high byte of a halfword
	assign tag_even = {history, bus.data[7:0]};
	assign tag_odd  = {history[`FLASH_TAG_W-17:0], bus.data[7:0], bus.data[15:8]};

	// ==================================================
	// Stream history and title capture
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (cart_start) begin
			history <= '0;
			cart_id <= '0;
		end else if (cart_wr) begin
			history <= {history[`FLASH_TAG_W-25:0], bus.data[7:0], bus.data[15:8]};
			if (title_line && bus.addr[3:0] < `HEADER_ID_CHECK)
				cart_id[id_lsb +: 16] <= {bus.data[7:0], bus.data[15:8]};
		end
	end

	// ==================================================
	// Results
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || cart_start) begin
			flash_1m <= 1'b0;
			quirks   <= '0;
		end else if (cart_wr) begin
			if (tag_even == `FLASH_TAG || tag_odd == `FLASH_TAG)
				flash_1m <= 1'b1;
			// Title is complete by offset AC
			if (title_line && bus.addr[3:0] == `HEADER_ID_CHECK)
				quirks <= quirks | quirk_lookup(cart_id);
		end
	end

endmodule

// File: logic/cheat_code_packer.sv
`timescale 1ns/100ps
/* Builds 128-bit cheat codes from the download bus, eight halfwords per code.
   Clears the code list at the start of a cheat download */
`include "gba_loader_settings.svh"

module cheat_code_packer import gba_loader_pkg::*; (
	input  logic            clk_sys,
	input  logic            reset,
	download_bus_if.sink    bus,
	input  logic            ioctl_download,
	input  load_index_t     ioctl_index,
	output cheat_code_t     cheat_code,
	output logic            cheat_valid,
	output logic            cheat_clear
);
	logic take;
	logic download_d;

	assign take = bus.cheat_load & bus.wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d  <= 1'b0;
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			download_d  <= ioctl_download;
			cheat_clear <= ioctl_download & ~download_d & (ioctl_index == `INDEX_CHEAT);
			cheat_valid <= take & (bus.addr[3:0] == 4'd14); // Last halfword
		end
	end

	// Low halfword of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (bus.addr[3:0])
				4'd0:  cheat_code[111:96]  <= bus.data; // Flags
				4'd2:  cheat_code[127:112] <= bus.data;
				4'd4:  cheat_code[79:64]   <= bus.data; // Address
				4'd6:  cheat_code[95:80]   <= bus.data;
				4'd8:  cheat_code[47:32]   <= bus.data; // Compare
				4'd10: cheat_code[63:48]   <= bus.data;
				4'd12: cheat_code[15:0]    <= bus.data; // Replace
				4'd14: cheat_code[31:16]   <= bus.data;
				default: ;
			endcase
		end
	end

endmodule

// File: logic/download_bus_if.sv
`timescale 1ns/100ps
/* Internal download bus. The decoder drives the registered kind flags
   and the raw write stream, the packers and the header scanner listen */

interface download_bus_if import gba_loader_pkg::*; ();

	logic       bios_load;  // Registered kind flags
	logic       cheat_load;
	logic       cart_load;

	logic       wr;         // Raw write stream from the host
	load_addr_t addr;
	load_data_t data;

	modport source (
		output bios_load, cheat_load, cart_load,
		output wr, addr, data
	);

	modport sink (
		input bios_load, cheat_load, cart_load,
		input wr, addr, data
	);

endinterface

// File: logic/download_decoder.sv
`timescale 1ns/100ps
/* Sorts host downloads by index and drives the download bus.
   Also gives the cartridge start pulse, type, loaded flag and last address */
`include "gba_loader_settings.svh"

module download_decoder import gba_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  load_index_t           ioctl_index,
	input  load_addr_t            ioctl_addr,
	input  load_data_t            ioctl_dout,
	input  logic                  ioctl_wr,
	download_bus_if.source        bus,
	output logic                  cart_start,
	output cart_type_t            cart_type,
	output logic                  cart_loaded,
	output pak_addr_t             pak_last_word
);
	logic is_bios;
	logic is_cheat;
	logic cart_load_d; // Cart flag one cycle back

	assign is_bios  = (ioctl_index == `INDEX_BIOS);
	assign is_cheat = (ioctl_index == `INDEX_CHEAT);

	// Write stream passes through unregistered
	assign bus.wr   = ioctl_wr;
	assign bus.addr = ioctl_addr;
	assign bus.data = ioctl_dout;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus.bios_load  <= 1'b0;
			bus.cheat_load <= 1'b0;
			bus.cart_load  <= 1'b0;
			cart_load_d    <= 1'b0;
		end else begin
			bus.bios_load  <= ioctl_download & is_bios;
			bus.cheat_load <= ioctl_download & is_cheat;
			bus.cart_load  <= ioctl_download & ~is_bios & ~is_cheat; // Anything else is ROM
			cart_load_d    <= bus.cart_load;
		end
	end

	assign cart_start = bus.cart_load & ~cart_load_d;

	always_ff @(posedge clk_sys) begin
		if (reset)
			cart_loaded <= 1'b0;
		else if (cart_start)
			cart_loaded <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (cart_start)
			cart_type <= ioctl_index[`LOAD_INDEX_W-1 -: `CART_TYPE_W];
		// Host still holds the last address when the flag drops
		if (~bus.cart_load & cart_load_d)
			pak_last_word <= ioctl_addr[`LOAD_ADDR_W-1:2];
	end

endmodule

// File: logic/gba_loader_pkg.sv
/* Vector types shared by the download front end.
   Modules pull these in with a wildcard import in their header */
`include "gba_loader_settings.svh"

package gba_loader_pkg;

	// ==================================================
	// Host download port
	// ==================================================
	typedef logic [`LOAD_ADDR_W-1:0]  load_addr_t;
	typedef logic [`LOAD_DATA_W-1:0]  load_data_t;
	typedef logic [`LOAD_INDEX_W-1:0] load_index_t;

	// BIOS write port of the core
	typedef logic [`BIOS_ADDR_W-1:0]  bios_addr_t; // Word address
	typedef logic [`BIOS_WORD_W-1:0]  bios_word_t;

	// Flags, address, compare, replace; 32 bits each, flags on top
	typedef logic [`CHEAT_CODE_W-1:0] cheat_code_t;

	// ==================================================
	// Cartridge
	// ==================================================
	typedef logic [`CART_TYPE_W-1:0]  cart_type_t; // Index bits 7..6
	typedef logic [`PAK_ADDR_W-1:0]   pak_addr_t;  // Last loaded word
	typedef logic [`QUIRK_W-1:0]      quirk_set_t;
	typedef logic [`HEADER_ID_W-1:0]  header_id_t; // First title char in the top byte

endpackage

// File: logic/gba_loader_settings.svh
/* Shared constants of the ROM download front end.
   Included by the package and by every module that needs a width or code */
`ifndef GBA_LOADER_SETTINGS_SVH
`define GBA_LOADER_SETTINGS_SVH

// ==================================================
// Widths
// ==================================================
`define LOAD_ADDR_W   27 // Host download byte address
`define LOAD_DATA_W   16 // One halfword per write
`define LOAD_INDEX_W  8
`define BIOS_ADDR_W   12
`define BIOS_WORD_W   32
`define CHEAT_CODE_W  128
`define CART_TYPE_W   2
`define PAK_ADDR_W    25 // Byte address bits 26..2
`define QUIRK_W       5
`define HEADER_ID_W   96 // 12 title bytes

// ==================================================
// Download indices and cartridge header
// ==================================================
`define INDEX_BIOS       8'd0
`define INDEX_CHEAT      8'd255
`define HEADER_ID_LINE   23'hA // Title sits at A0..AB
`define HEADER_ID_CHECK  4'd12 // Offset AC, title complete
`define FLASH_TAG        "FLASH1M_V"
`define FLASH_TAG_W      72

// Bit positions in a quirk set
`define QUIRK_SRAM   0
`define QUIRK_REMAP  1
`define QUIRK_GPIO   2
`define QUIRK_TILT   3
`define QUIRK_SOLAR  4

`endif

// File: logic/gba_loader_top.sv
`timescale 1ns/100ps
/* Top of the ROM download front end. Host download port in,
   BIOS, cheat and cartridge loads for the emulator core out */
`include "gba_loader_settings.svh"

module gba_loader_top import gba_loader_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,

	// Host download port
	input  logic         ioctl_download,
	input  load_index_t  ioctl_index,
	input  load_addr_t   ioctl_addr,
	input  load_data_t   ioctl_dout,
	input  logic         ioctl_wr,

	input  logic         bios_lock,     // Built-in boot code in use

	// BIOS loads
	output bios_addr_t   bios_wraddr,
	output bios_word_t   bios_wrdata,
	output logic         bios_wr,

	// Cheat codes
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_clear,

	// Cartridge info
	output cart_type_t   cart_type,
	output logic         cart_loaded,
	output pak_addr_t    pak_last_word,
	output logic         flash_1m,
	output logic         sram_quirk,
	output logic         remap_quirk,
	output logic         gpio_quirk,
	output logic         tilt_quirk,
	output logic         solar_quirk
);
	logic       cart_start;
	quirk_set_t quirks;

	download_bus_if dl_bus ();

	download_decoder decoder_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.bus            (dl_bus),
		.cart_start     (cart_start),
		.cart_type      (cart_type),
		.cart_loaded    (cart_loaded),
		.pak_last_word  (pak_last_word)
	);

	bios_word_packer bios_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (dl_bus),
		.bios_lock   (bios_lock),
		.bios_wraddr (bios_wraddr),
		.bios_wrdata (bios_wrdata),
		.bios_wr     (bios_wr)
	);

	cheat_code_packer cheat_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus            (dl_bus),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid),
		.cheat_clear    (cheat_clear)
	);

	cart_header_scan scan_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (dl_bus),
		.cart_start (cart_start),
		.flash_1m   (flash_1m),
		.quirks     (quirks)
	);

	// Named quirk outputs
	assign sram_quirk  = quirks[`QUIRK_SRAM];
	assign remap_quirk = quirks[`QUIRK_REMAP];
	assign gpio_quirk  = quirks[`QUIRK_GPIO];
	assign tilt_quirk  = quirks[`QUIRK_TILT];
	assign solar_quirk = quirks[`QUIRK_SOLAR];

endmodule

// File: verif/gba_loader_tb.sv
`timescale 1ns/100ps
/* Testbench of the ROM download front end. Sends BIOS, cheat and cartridge
   downloads through the host port and checks the loads against reference models */
`include "gba_loader_settings.svh"

module gba_loader_tb import gba_loader_pkg::*; ();

	localparam int BIOS_HALVES     = 64;
	localparam int CHEAT_CODES     = 3;
	localparam int TOTAL_WRITES    = 2 * BIOS_HALVES + 8 * CHEAT_CODES + 96 + 120 + 3 * 256
	                                 + 9 * 96;
	localparam int WATCHDOG_CYCLES = TOTAL_WRITES * 4 + 2000;
	localparam logic [71:0] FLASH_TEXT = "FLASH1M_V"; // First character on top

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         ioctl_download;
	load_index_t  ioctl_index;
	load_addr_t   ioctl_addr;
	load_data_t   ioctl_dout;
	logic         ioctl_wr;
	logic         bios_lock;
	bios_addr_t   bios_wraddr;
	bios_word_t   bios_wrdata;
	logic         bios_wr;
	cheat_code_t  cheat_code;
	logic         cheat_valid;
	logic         cheat_clear;
	cart_type_t   cart_type;
	logic         cart_loaded;
	pak_addr_t    pak_last_word;
	logic         flash_1m;
	logic         sram_quirk;
	logic         remap_quirk;
	logic         gpio_quirk;
	logic         tilt_quirk;
	logic         solar_quirk;
	quirk_set_t   quirks_seen;

	logic [43:0]  bios_exp [$];  // {word address, data}
	cheat_code_t  cheat_exp [$];
	logic [43:0]  bios_head;
	cheat_code_t  cheat_head;
	int           errors = 0;
	int           checks = 0;
	int           clears_seen = 0;
	logic [7:0]   rom [0:511];   // Cartridge image, one byte per address
	string        titles [9] = '{"ROCKY BOXING", "BOMBER MAN", "ZELDA 1", "POKEMON EMER",
	                             "BOKTAI", "WARIOTWISTED", "YOSHI TOPSY", "SENNENKAZOKU",
	                             "UNKNOWN GAME"};

	always #5 clk_sys = ~clk_sys;

	assign quirks_seen = {solar_quirk, tilt_quirk, gpio_quirk, remap_quirk, sram_quirk};

	gba_loader_top dut_i (.*);

	// ==================================================
	// Reference models
	// ==================================================
	function automatic logic [43:0] bios_ref(input load_addr_t addr, input load_data_t lo,
	                                         input load_data_t hi);
		return {addr[13:2], hi, lo};
	endfunction

	// Halfword j of a code sits at stream[16*j +: 16], in download order
	function automatic cheat_code_t cheat_ref(input logic [127:0] stream);
		cheat_code_t code;
		for (int f = 0; f < 4; f++)
			code[127 - 32 * f -: 32] = stream[32 * f +: 32]; // Flags first, low half first
		return code;
	endfunction

	function automatic logic tag_ref(input int n_bytes);
		logic found;
		logic same;
		found = 1'b0;
		for (int k = 0; k + 9 <= n_bytes; k++) begin
			same = 1'b1;
			for (int i = 0; i < 9; i++)
				if (rom[k + i] != FLASH_TEXT[71 - 8 * i -: 8])
					same = 1'b0;
			found |= same;
		end
		return found;
	endfunction

	function automatic quirk_set_t quirk_ref(input string title);
		quirk_set_t q;
		q = '0;
		if (title == "ROCKY BOXING") begin
			q[`QUIRK_SRAM] = 1'b1;
		end else if (title == "BOMBER MAN" || title == "ZELDA 1") begin
			q[`QUIRK_SRAM]  = 1'b1;
			q[`QUIRK_REMAP] = 1'b1;
		end else if (title == "POKEMON EMER" || title == "WARIOTWISTED"
		             || title == "SENNENKAZOKU") begin
			q[`QUIRK_GPIO] = 1'b1;
		end else if (title == "BOKTAI") begin
			q[`QUIRK_GPIO]  = 1'b1;
			q[`QUIRK_SOLAR] = 1'b1;
		end else if (title == "YOSHI TOPSY") begin
			q[`QUIRK_TILT] = 1'b1;
		end
		return q;
	endfunction

	// ==================================================
	// Check helpers and host port tasks
	// ==================================================
	task automatic compare_value(input string what, input logic [127:0] got,
	                             input logic [127:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic expect_count(input string what, input int seen, input int want);
		checks++;
		assert (seen == want) else begin
			errors++;
			$display("Error: wrong number of %s, %0d instead of %0d", what, seen, want);
		end
	endtask

	task automatic write_half(input load_addr_t addr, input load_data_t data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat ($urandom % 2) @(posedge clk_sys); // Uneven host pacing
	endtask

	task automatic start_download(input load_index_t index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	// Address stays on the last write while the download drops
	task automatic end_download();
		repeat (2) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic load_bios(input logic lock);
		load_addr_t base;
		load_data_t lo;
		load_data_t hi;
		base = load_addr_t'(($urandom % 32'h3F0) * 16);
		@(posedge clk_sys);
		bios_lock <= lock;
		start_download(8'd0);
		for (int w = 0; w < BIOS_HALVES / 2; w++) begin
			lo = load_data_t'($urandom);
			hi = load_data_t'($urandom);
			write_half(load_addr_t'(base + 4 * w), lo);
			if (!lock)
				bios_exp.push_back(bios_ref(load_addr_t'(base + 4 * w + 2), lo, hi));
			write_half(load_addr_t'(base + 4 * w + 2), hi);
		end
		end_download();
		expect_count("BIOS words left unwritten", bios_exp.size(), 0);
		@(posedge clk_sys);
		bios_lock <= 1'b0;
	endtask

	task automatic load_cheats();
		logic [127:0] stream;
		int           clears_before;
		clears_before = clears_seen;
		start_download(8'hFF);
		for (int c = 0; c < CHEAT_CODES; c++) begin
			stream = {$urandom, $urandom, $urandom, $urandom};
			cheat_exp.push_back(cheat_ref(stream));
			for (int j = 0; j < 8; j++)
				write_half(load_addr_t'(16 * c + 2 * j), stream[16 * j +: 16]);
		end
		end_download();
		expect_count("cheat codes left unsent", cheat_exp.size(), 0);
		expect_count("cheat_clear pulses in the cheat download", clears_seen - clears_before, 1);
	endtask

	// tag_at below zero leaves the flash tag out
	task automatic load_cart(input load_index_t index, input int halves, input string title,
	                         input int tag_at);
		load_addr_t last_addr;
		for (int b = 0; b < 2 * halves; b++)
			rom[b] = 8'($urandom);
		for (int i = 0; i < 12; i++)
			rom['hA0 + i] = (i < title.len()) ? title[i] : 8'h00; // Zero padded title
		if (tag_at >= 0)
			for (int i = 0; i < 9; i++)
				rom[tag_at + i] = FLASH_TEXT[71 - 8 * i -: 8];
		start_download(index);
		@(negedge clk_sys);
		compare_value("flash_1m at cartridge start", flash_1m, 0);
		compare_value("quirks at cartridge start", quirks_seen, 0);
		for (int h = 0; h < halves; h++)
			write_half(load_addr_t'(2 * h), {rom[2 * h + 1], rom[2 * h]});
		last_addr = load_addr_t'(2 * (halves - 1));
		end_download();
		compare_value("cart_type", cart_type, index[7:6]);
		compare_value("cart_loaded", cart_loaded, 1);
		compare_value("pak_last_word", pak_last_word, last_addr[26:2]);
		compare_value({"flash_1m of ", title}, flash_1m, tag_ref(2 * halves));
		compare_value({"quirks of ", title}, quirks_seen, quirk_ref(title));
	endtask

	// ==================================================
	// Strobe comparison
	// ==================================================
	always @(negedge clk_sys) begin
		if (cheat_clear)
			clears_seen++;
		if (bios_wr) begin
			assert (bios_exp.size() > 0) else begin
				errors++;
				$display("Error: bios_wr pulsed at %0d ns with no word expected", $time);
			end
			if (bios_exp.size() > 0) begin
				bios_head = bios_exp.pop_front();
				checks++;
				assert ({bios_wraddr, bios_wrdata} == bios_head) else begin
					errors++;
					$display("Fail at %0d ns: BIOS word %h:%h, expected %h:%h", $time,
					         bios_wraddr, bios_wrdata, bios_head[43:32], bios_head[31:0]);
				end
			end
		end
		if (cheat_valid) begin
			assert (cheat_exp.size() > 0) else begin
				errors++;
				$display("Error: cheat_valid pulsed at %0d ns with no code expected", $time);
			end
			if (cheat_exp.size() > 0) begin
				cheat_head = cheat_exp.pop_front();
				checks++;
				assert (cheat_code == cheat_head) else begin
					errors++;
					$display("Fail at %0d ns: cheat_code %h, expected %h", $time,
					         cheat_code, cheat_head);
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Error: watchdog expired after %0d cycles, tests did not finish",
		         WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		void'($urandom(32'hb21f));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		bios_lock      = 1'b0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		compare_value("bios_wr after reset", bios_wr, 0);
		compare_value("cheat_valid after reset", cheat_valid, 0);
		compare_value("cheat_clear after reset", cheat_clear, 0);
		compare_value("cart_loaded after reset", cart_loaded, 0);
		compare_value("flash_1m after reset", flash_1m, 0);
		compare_value("quirks after reset", quirks_seen, 0);

		load_bios(1'b0);
		load_bios(1'b1); // Built-in boot code, no writes
		load_cheats();
		load_cart(8'd1, 96, "TEST CART 01", -1);
		load_cart(8'd65, 120, "TEST CART 65", -1);
		load_cart(8'd130, 256, "SAVE EVEN", 300);
		load_cart(8'd193, 256, "SAVE ODD", 301);
		load_cart(8'd2, 256, "SAVE NONE", -1);
		for (int t = 0; t < 9; t++)
			load_cart(load_index_t'(1 + 64 * (t % 4)), 96, titles[t], -1);
		expect_count("cheat_clear pulses over the whole run", clears_seen, 1);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
